//--- dv/datapath_core_sva.sv
`timescale 1ns/10ps

module datapath_core_sva
    import dsp_pkg::*;
(
    input logic    clk_i,
    input logic    rst_i,
    input s3_out_t s3_i,
    input s4_out_t s4_i
);

    // Number of failed assertions so far
    int fail_count = 0;

    // Bits and errors both clear on reset
    assert property (@(posedge clk_i) rst_i |=> s4_i == '0)
        else begin
            $error("corrector output not zero after reset");
            fail_count++;
        end

    // A bit may only differ from its input where the flag was raised
    assert property (@(posedge clk_i) disable iff (rst_i)
        !rst_i |=> ((s4_i.bits ^ $past(s3_i.bits)) & ~$past(s3_i.flags)) == '0)
        else begin
            $error("corrected bit changed on an unflagged lane");
            fail_count++;
        end

    // Unflagged lanes pass their error through
    for (genvar i = 0; i < num_lanes; i++) begin : g_lane
        assert property (@(posedge clk_i) disable iff (rst_i)
            !rst_i && !s3_i.flags[i] |=> s4_i.errs[i] == $past(s3_i.errs[i]))
            else begin
                $error("lane %0d error changed without a flag", i);
                fail_count++;
            end
    end

endmodule

//--- dv/datapath_core_tb.sv
`timescale 1ns/10ps

module datapath_core_tb
    import dsp_pkg::*;
();

    localparam int num_rand  = 64;
    localparam int flush_len = 3;
    localparam int mem_words = 512;

    logic                 clk;
    logic                 rst;
    lane_codes_t          adc_codes;
    dsp_cfg_t             cfg;
    s4_out_t              s4;
    s2_out_t              aligned_s2;
    logic [num_lanes-1:0] aligned_flags;

    logic [31:0] pat_mem [0:mem_words-1];
    lane_codes_t stim_q[$];
    int          file_exp_q[$];
    s2_out_t     s2_model_q[$];
    int          file_bits_q[$];

    // Model history, reset values of the DUT
    code_t hist_old = '0;
    code_t hist_new = '0;
    logic  prev_bit_m = 1'b0;

    int cycles = 0;
    int cycle_limit = 0;
    int n_checks = 0;
    int model_errs = 0;
    int file_errs = 0;
    int sva_errs = 0;

    datapath_core dut0 (
        .clk_i              (clk),
        .rst_i              (rst),
        .adc_codes_i        (adc_codes),
        .cfg_i              (cfg),
        .s4_o               (s4),
        .aligned_s2_o       (aligned_s2),
        .aligned_s3_flags_o (aligned_flags)
    );

    bind error_corrector datapath_core_sva sva0 (
        .clk_i (clk_i),
        .rst_i (rst_i),
        .s3_i  (s3_i),
        .s4_i  (s4_o)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #2 clk = ~clk;
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycle_limit > 0 && cycles >= cycle_limit) begin
            $display("Timeout: run still going after %0d cycles", cycles);
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    function automatic int sym(input logic b);
        return b ? 1 : -1;
    endfunction

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic err_t to_err(input int v);
        return v[$bits(err_t)-1:0];
    endfunction

    // FFE and sign slicer over the serial window, oldest code first
    function automatic logic [num_lanes-1:0] slice_codes(input lane_codes_t c,
                                                         input code_t older, input code_t newer);
        int                   win [num_lanes+ffe_hist];
        int                   est;
        logic [num_lanes-1:0] b;
        win[0] = older;
        win[1] = newer;
        for (int i = 0; i < num_lanes; i++) begin
            win[i+ffe_hist] = c[i];
        end
        for (int i = 0; i < num_lanes; i++) begin
            est = 0;
            for (int k = 0; k < ffe_taps; k++) begin
                est = est + int'(cfg.weights[k]) * win[i+ffe_hist-k];
            end
            est  = est >>> cfg.ffe_shift;
            b[i] = (est >= 0);
        end
        return b;
    endfunction

    // Code minus the two-cursor prediction
    function automatic s2_out_t residual_vec(input lane_codes_t c,
                                             input logic [num_lanes-1:0] b, input logic pb);
        s2_out_t r;
        int      pred;
        logic    prev;
        r.bits = b;
        prev   = pb;
        for (int i = 0; i < num_lanes; i++) begin
            pred      = sym(b[i]) * int'(cfg.h0) + sym(prev) * int'(cfg.h1);
            pred      = pred >>> cfg.chan_shift;
            r.errs[i] = to_err(int'(c[i]) - pred);
            prev      = b[i];
        end
        return r;
    endfunction

    // True when the opposite symbol leaves less error energy
    function automatic logic flip_wins(input err_t e, input logic b, output int flipped);
        int h0s;
        int ei;
        h0s     = cfg.h0;
        h0s     = h0s >>> cfg.chan_shift;
        ei      = e;
        flipped = ei + 2 * sym(b) * h0s;
        return flipped * flipped < ei * ei;
    endfunction

    task automatic model_push(input lane_codes_t c);
        logic [num_lanes-1:0] b;
        b = slice_codes(c, hist_old, hist_new);
        s2_model_q.push_back(residual_vec(c, b, prev_bit_m));
        hist_old   = c[num_lanes-2];
        hist_new   = c[num_lanes-1];
        prev_bit_m = b[num_lanes-1];
    endtask

    task automatic check_value(input string name, input logic [63:0] exp, input logic [63:0] got);
        n_checks++;
        if (got !== exp) begin
            model_errs++;
            $display("[FAIL] %s expected %h got %h at cycle %0d", name, exp, got, cycles);
        end
    endtask

    task automatic check_outputs();
        s2_out_t              x;
        s4_out_t              exp4;
        logic [num_lanes-1:0] flags;
        int                   flipped;
        int                   fb;
        x  = s2_model_q.pop_front();
        fb = file_bits_q.pop_front();
        for (int i = 0; i < num_lanes; i++) begin
            flags[i]     = flip_wins(x.errs[i], x.bits[i], flipped);
            exp4.bits[i] = x.bits[i] ^ flags[i];
            exp4.errs[i] = flags[i] ? to_err(flipped) : x.errs[i];
        end
        check_value("aligned_s2_o", x, aligned_s2);
        check_value("aligned_s3_flags_o", flags, aligned_flags);
        check_value("s4_o.bits", exp4.bits, s4.bits);
        check_value("s4_o.errs", exp4.errs, s4.errs);
        if (fb >= 0) begin
            n_checks++;
            if (s4.bits !== fb[num_lanes-1:0]) begin
                file_errs++;
                $display("[FAIL] s4_o.bits expected %h (pattern file) got %h at cycle %0d",
                         fb[num_lanes-1:0], s4.bits, cycles);
            end
        end
    endtask

    initial begin
        int          a;
        logic [31:0] seed;
        lane_codes_t c;
        rst       = 1'b1;
        adc_codes = '0;
        cfg       = '0;
        // Unread words keep an address-tagged marker
        for (int i = 0; i < mem_words; i++) begin
            pat_mem[i] = 32'hee00_0000 | i;
        end
        $readmemh("dv/datapath_patterns.txt", pat_mem);
        cfg.weights[0] = pat_mem[0][5:0];
        cfg.weights[1] = pat_mem[1][5:0];
        cfg.weights[2] = pat_mem[2][5:0];
        cfg.ffe_shift  = pat_mem[3][2:0];
        cfg.h0         = pat_mem[4][7:0];
        cfg.h1         = pat_mem[5][7:0];
        cfg.chan_shift = pat_mem[6][2:0];
        a = 7;
        while (a + 4 < mem_words && pat_mem[a][31:24] != 8'hee) begin
            for (int i = 0; i < num_lanes; i++) begin
                c[i] = pat_mem[a+i][7:0];
            end
            stim_q.push_back(c);
            file_exp_q.push_back(pat_mem[a+4][num_lanes-1:0]);
            a = a + 5;
        end
        if (stim_q.size() == 0) begin
            file_errs++;
            $display("No vectors could be read from the pattern file");
        end
        seed = 32'hadfc;
        repeat (num_rand) begin
            for (int i = 0; i < num_lanes; i++) begin
                seed = lcg_next(seed);
                c[i] = seed[31:24];
            end
            stim_q.push_back(c);
            file_exp_q.push_back(-1);
        end
        // Zero vectors push the last real vector out of the pipeline
        repeat (flush_len) begin
            stim_q.push_back('0);
            file_exp_q.push_back(-1);
        end
        cycle_limit = stim_q.size() + 20;

        // Three outputs drain the reset contents of stages 1 to 3
        s2_model_q.push_back('0);
        s2_model_q.push_back('0);
        s2_model_q.push_back(residual_vec('0, '0, 1'b0));
        repeat (flush_len) begin
            file_bits_q.push_back(-1);
        end

        repeat (5) @(posedge clk);
        #1;
        check_value("s4_o in reset", '0, s4);
        check_value("aligned_s2_o in reset", '0, aligned_s2);
        check_value("aligned_s3_flags_o in reset", '0, aligned_flags);
        rst = 1'b0;
        for (int v = 0; v < stim_q.size(); v++) begin
            adc_codes = stim_q[v];
            model_push(stim_q[v]);
            file_bits_q.push_back(file_exp_q[v]);
            @(posedge clk);
            #1;
            check_outputs();
        end

        sva_errs = dut0.u_error_corrector.sva0.fail_count;
        $display("Checks %0d, model mismatches %0d, pattern mismatches %0d, assertion fails %0d",
                 n_checks, model_errs, file_errs, sva_errs);
        if (model_errs + file_errs + sva_errs == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

//--- dv/datapath_patterns.txt
// Config: w0 w1 w2 ffe_shift h0 h1 chan_shift
// Vectors: code0 code1 code2 code3 corrected_bits (bit i is lane i)
01 00 00 0 28 0a 0
// Large codes, no flips
32 c4 46 b0 5
64 5a 9c a6 3
// Codes near zero force flips
05 14 03 fc 3
fd fb 08 09 7
00 00 00 00 0
ff 0a 09 f6 2
f7 f6 fe 7f d
80 01 f9 06 a
07 08 fa fb 8
1e 28 32 3c f
e2 d8 ce c4 0
02 fe 02 fe 5
fe 02 02 fe 3
09 09 09 09 1
f7 f7 f7 f7 e
// Extremes and flip boundaries
7f 80 7f 80 5
0a f6 0b f5 5
40 09 c0 f7 9
00 ff 00 ff 5
19 03 e7 fd 9
50 50 05 50 b
b0 b0 fb b0 4
0f f1 2d d3 5
fa 04 fd 01 b
04 64 9c 03 a
01 01 01 01 0

//--- list.f
rtl/dsp_pkg.sv
rtl/ffe_slicer.sv
rtl/res_err_estimator.sv
rtl/error_checker.sv
rtl/error_corrector.sv
rtl/align_buffer.sv
rtl/datapath_core.sv
dv/datapath_core_sva.sv
dv/datapath_core_tb.sv

//--- rtl/align_buffer.sv
`timescale 1ns/10ps

module align_buffer #(
    parameter int width = 8,
    parameter int depth = 1
) (
    input  logic             clk_i,
    input  logic             rst_i,
    input  logic [width-1:0] data_i,
    output logic [width-1:0] data_o
);

    // Entry 0 is the newest
    logic [depth-1:0][width-1:0] pipe_q;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            pipe_q <= '0;
        end else begin
            pipe_q[0] <= data_i;
            for (int i = 1; i < depth; i++) begin
                pipe_q[i] <= pipe_q[i-1];
            end
        end
    end

    assign data_o = pipe_q[depth-1];

endmodule

//--- rtl/datapath_core.sv
`timescale 1ns/10ps

module datapath_core
    import dsp_pkg::*;
(
    input  logic                 clk_i,
    input  logic                 rst_i,
    input  lane_codes_t          adc_codes_i,
    input  dsp_cfg_t             cfg_i,
    output s4_out_t              s4_o,
    output s2_out_t              aligned_s2_o,
    output logic [num_lanes-1:0] aligned_s3_flags_o
);

    s1_out_t s1;
    s2_out_t s2;
    s3_out_t s3;

    // FFE and slicer
    ffe_slicer u_ffe_slicer (
        .clk_i   (clk_i),
        .rst_i   (rst_i),
        .codes_i (adc_codes_i),
        .cfg_i   (cfg_i),
        .s1_o    (s1)
    );

    // Residual error against the channel estimate
    res_err_estimator u_res_err_estimator (
        .clk_i (clk_i),
        .rst_i (rst_i),
        .s1_i  (s1),
        .cfg_i (cfg_i),
        .s2_o  (s2)
    );

    // Single-bit flip detection
    error_checker u_error_checker (
        .clk_i (clk_i),
        .rst_i (rst_i),
        .s2_i  (s2),
        .cfg_i (cfg_i),
        .s3_o  (s3)
    );

    error_corrector u_error_corrector (
        .clk_i (clk_i),
        .rst_i (rst_i),
        .s3_i  (s3),
        .cfg_i (cfg_i),
        .s4_o  (s4_o)
    );

    // Stage 2 bits and errors held back to meet the stage 4 output
    align_buffer #(
        .width ($bits(s2_out_t)),
        .depth (s2_align_depth)
    ) s2_align (
        .clk_i  (clk_i),
        .rst_i  (rst_i),
        .data_i (s2),
        .data_o (aligned_s2_o)
    );

    align_buffer #(
        .width (num_lanes),
        .depth (s3_align_depth)
    ) s3_align (
        .clk_i  (clk_i),
        .rst_i  (rst_i),
        .data_i (s3.flags),
        .data_o (aligned_s3_flags_o)
    );

endmodule

//--- rtl/dsp_pkg.sv
package dsp_pkg;

    // Lane and tap counts
    localparam int num_lanes = 4;
    localparam int ffe_taps  = 3;
    localparam int ffe_hist  = ffe_taps - 1;

    // Register stages per block
    localparam int s1_depth = 1;
    localparam int s2_depth = 1;
    localparam int s3_depth = 1;
    localparam int s4_depth = 1;

    // Delay needed to line earlier results up with the stage 4 output
    localparam int s2_align_depth = s4_depth + s3_depth;
    localparam int s3_align_depth = s4_depth;
    localparam int core_latency   = s1_depth + s2_depth + s3_depth + s4_depth;

    typedef logic signed [7:0]  code_t;
    typedef logic signed [5:0]  weight_t;
    typedef logic        [2:0]  shift_t;
    typedef logic signed [15:0] est_t;
    typedef logic signed [7:0]  chan_t;
    typedef logic signed [9:0]  err_t;
    typedef logic        [19:0] ener_t;

    // Signed cursor, cursor sum and flipped error, each wide enough to avoid overflow
    typedef logic signed [8:0]  scur_t;
    typedef logic signed [9:0]  pred_t;
    typedef logic signed [11:0] flip_t;

    typedef code_t [num_lanes-1:0] lane_codes_t;
    typedef est_t  [num_lanes-1:0] lane_est_t;
    typedef err_t  [num_lanes-1:0] lane_errs_t;
    typedef ener_t [num_lanes-1:0] lane_ener_t;

    typedef struct packed {
        weight_t [ffe_taps-1:0] weights;
        shift_t                 ffe_shift;
        chan_t                  h0;
        chan_t                  h1;
        shift_t                 chan_shift;
    } dsp_cfg_t;

    typedef struct packed {
        lane_est_t            est;
        logic [num_lanes-1:0] bits;
        lane_codes_t          codes;
    } s1_out_t;

    typedef struct packed {
        logic [num_lanes-1:0] bits;
        lane_errs_t           errs;
    } s2_out_t;

    typedef struct packed {
        logic [num_lanes-1:0] bits;
        lane_errs_t           errs;
        logic [num_lanes-1:0] flags;
        lane_ener_t           ener;
    } s3_out_t;

    typedef struct packed {
        logic [num_lanes-1:0] bits;
        lane_errs_t           errs;
    } s4_out_t;

    // +h for bit 1, -h for bit 0
    function automatic scur_t sym_mul(input logic b, input chan_t h);
        scur_t hx;
        hx = h;
        return b ? hx : -hx;
    endfunction

    // Residual error if the sliced bit were the other symbol
    function automatic flip_t flip_err(input err_t e, input logic b, input chan_t h0,
                                       input shift_t sh);
        chan_t h0_sh;
        h0_sh = h0 >>> sh;
        return e + 2 * sym_mul(b, h0_sh);
    endfunction

endpackage

//--- rtl/error_checker.sv
`timescale 1ns/10ps

module error_checker
    import dsp_pkg::*;
(
    input  logic     clk_i,
    input  logic     rst_i,
    input  s2_out_t  s2_i,
    input  dsp_cfg_t cfg_i,
    output s3_out_t  s3_o
);

    logic [num_lanes-1:0] flags_c;
    lane_ener_t           ener_c;

    always_comb begin : flip_test
        flip_t       flip;
        logic [23:0] flip_sq;
        ener_t       err_sq;
        for (int i = 0; i < num_lanes; i++) begin
            flip    = flip_err(s2_i.errs[i], s2_i.bits[i], cfg_i.h0, cfg_i.chan_shift);
            // Both squares fit, so the low bits of each product are exact
            flip_sq = flip * flip;
            err_sq  = s2_i.errs[i] * s2_i.errs[i];

            ener_c[i] = err_sq;
            // Strictly lower energy needed, ties keep the slicer decision
            flags_c[i] = flip_sq < {4'b0, err_sq};
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            s3_o <= '0;
        end else begin
            s3_o.bits  <= s2_i.bits;
            s3_o.errs  <= s2_i.errs;
            s3_o.flags <= flags_c;
            s3_o.ener  <= ener_c;
        end
    end

endmodule

//--- rtl/error_corrector.sv
`timescale 1ns/10ps

module error_corrector
    import dsp_pkg::*;
(
    input  logic     clk_i,
    input  logic     rst_i,
    input  s3_out_t  s3_i,
    input  dsp_cfg_t cfg_i,
    output s4_out_t  s4_o
);

    logic [num_lanes-1:0] bits_c;
    lane_errs_t           errs_c;

    always_comb begin : correct
        flip_t flip;
        for (int i = 0; i < num_lanes; i++) begin
            // Same hypothesis error the checker compared against
            flip = flip_err(s3_i.errs[i], s3_i.bits[i], cfg_i.h0, cfg_i.chan_shift);
            bits_c[i] = s3_i.bits[i] ^ s3_i.flags[i];
            errs_c[i] = s3_i.flags[i] ? err_t'(flip) : s3_i.errs[i];
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            s4_o <= '0;
        end else begin
            s4_o.bits <= bits_c;
            s4_o.errs <= errs_c;
        end
    end

endmodule

//--- rtl/ffe_slicer.sv
`timescale 1ns/10ps

module ffe_slicer
    import dsp_pkg::*;
(
    input  logic        clk_i,
    input  logic        rst_i,
    input  lane_codes_t codes_i,
    input  dsp_cfg_t    cfg_i,
    output s1_out_t     s1_o
);

    // Last lanes of the previous vector, oldest first
    code_t [ffe_hist-1:0] hist_q;

    // Sample window in serial order, history below the current lanes
    code_t [num_lanes+ffe_hist-1:0] win;

    lane_est_t            est_c;
    logic [num_lanes-1:0] bits_c;

    always_comb begin
        for (int j = 0; j < ffe_hist; j++) begin
            win[j] = hist_q[j];
        end
        for (int j = 0; j < num_lanes; j++) begin
            win[j+ffe_hist] = codes_i[j];
        end
    end

    always_comb begin : ffe_sum
        est_t acc;
        for (int i = 0; i < num_lanes; i++) begin
            acc = '0;
            // Tap k looks k samples back from lane i
            for (int k = 0; k < ffe_taps; k++) begin
                acc = acc + cfg_i.weights[k] * win[i+ffe_hist-k];
            end
            est_c[i]  = acc >>> cfg_i.ffe_shift;
            // Zero slices to bit 1
            bits_c[i] = ~est_c[i][$bits(est_t)-1];
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            hist_q <= '0;
            s1_o   <= '0;
        end else begin
            hist_q     <= codes_i[num_lanes-1 -: ffe_hist];
            s1_o.est   <= est_c;
            s1_o.bits  <= bits_c;
            s1_o.codes <= codes_i;
        end
    end

endmodule

//--- rtl/res_err_estimator.sv
`timescale 1ns/10ps

module res_err_estimator
    import dsp_pkg::*;
(
    input  logic     clk_i,
    input  logic     rst_i,
    input  s1_out_t  s1_i,
    input  dsp_cfg_t cfg_i,
    output s2_out_t  s2_o
);

    // Last bit of the previous vector, predecessor of lane 0
    logic prev_bit_q;

    // Each lane's predecessor bit in serial order
    logic [num_lanes-1:0] pred_bits;

    lane_errs_t errs_c;

    assign pred_bits = {s1_i.bits[num_lanes-2:0], prev_bit_q};

    always_comb begin : residual
        pred_t               pred;
        logic signed [10:0]  diff;
        for (int i = 0; i < num_lanes; i++) begin
            // Expected code from main cursor and first post-cursor
            pred = sym_mul(s1_i.bits[i], cfg_i.h0) + sym_mul(pred_bits[i], cfg_i.h1);
            diff = s1_i.codes[i] - (pred >>> cfg_i.chan_shift);
            errs_c[i] = err_t'(diff);
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            prev_bit_q <= 1'b0;
            s2_o       <= '0;
        end else begin
            prev_bit_q <= s1_i.bits[num_lanes-1];
            s2_o.bits  <= s1_i.bits;
            s2_o.errs  <= errs_c;
        end
    end

endmodule
